//--- trace_pkg.sv
package trace_pkg;

    // record geometry
    localparam int rec_words_lp = 5;
    localparam int fifo_depth_lp = 8;
    localparam int ptr_w_lp = $clog2(fifo_depth_lp);
    // level counts 0..depth inclusive
    localparam int level_w_lp = $clog2(fifo_depth_lp + 1);
    localparam int ovf_w_lp = 16;

    // word slots inside one record
    localparam int rec_stamp_lp = 0;
    localparam int rec_pc_lp = 1;
    localparam int rec_insn_lp = 2;
    localparam int rec_data_lp = 3;
    localparam int rec_meta_lp = 4;

    // five words, word 0 in the low bits
    typedef logic [rec_words_lp-1:0][31:0] rec_t;

    // meta word bit positions
    localparam int meta_trap_bit_lp = 0;
    localparam int meta_rd_we_bit_lp = 1;
    localparam int meta_csr_we_bit_lp = 2;
    localparam int meta_rd_lsb_lp = 3;
    localparam int meta_csr_lsb_lp = 8;
    localparam int meta_class_lsb_lp = 20;

    // base view, I-type style field split
    typedef struct packed {
        logic [11:0] upper;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } insn_base_t;

    // system view, top bits are the csr number
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } insn_sys_t;

    typedef union packed {
        insn_base_t base;
        insn_sys_t  sys;
    } insn_u;

    typedef enum logic [3:0] {
        class_load   = 4'd0,
        class_store  = 4'd1,
        class_branch = 4'd2,
        class_jal    = 4'd3,
        class_jalr   = 4'd4,
        class_op     = 4'd5,
        class_op_imm = 4'd6,
        class_lui    = 4'd7,
        class_auipc  = 4'd8,
        class_system = 4'd9,
        class_other  = 4'd10
    } insn_class_e;

    // rv32 major opcodes
    localparam logic [6:0] opc_load_lp = 7'b0000011;
    localparam logic [6:0] opc_store_lp = 7'b0100011;
    localparam logic [6:0] opc_branch_lp = 7'b1100011;
    localparam logic [6:0] opc_jal_lp = 7'b1101111;
    localparam logic [6:0] opc_jalr_lp = 7'b1100111;
    localparam logic [6:0] opc_op_lp = 7'b0110011;
    localparam logic [6:0] opc_op_imm_lp = 7'b0010011;
    localparam logic [6:0] opc_lui_lp = 7'b0110111;
    localparam logic [6:0] opc_auipc_lp = 7'b0010111;
    localparam logic [6:0] opc_system_lp = 7'b1110011;

    // axi register map
    localparam int axi_addr_w_lp = 8;
    localparam logic [axi_addr_w_lp-1:0] reg_ctrl_lp = 8'h00;
    localparam logic [axi_addr_w_lp-1:0] reg_status_lp = 8'h04;
    localparam logic [axi_addr_w_lp-1:0] reg_rec0_lp = 8'h10;
    localparam logic [axi_addr_w_lp-1:0] reg_rec1_lp = 8'h14;
    localparam logic [axi_addr_w_lp-1:0] reg_rec2_lp = 8'h18;
    localparam logic [axi_addr_w_lp-1:0] reg_rec3_lp = 8'h1c;
    localparam logic [axi_addr_w_lp-1:0] reg_rec4_lp = 8'h20;

endpackage

//--- trace_capture.sv
`timescale 1ns/1ps

module trace_capture (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               ret_valid,
    input  logic [31:0]        ret_pc,
    input  logic [31:0]        ret_insn,
    input  logic               ret_trap,
    input  logic               ret_rd_we,
    input  logic [4:0]         ret_rd_addr,
    input  logic [31:0]        ret_rd_wdata,
    input  logic               ret_csr_we,
    input  logic [31:0]        ret_csr_wdata,
    input  logic               cfg_enable,
    input  logic               cfg_trap_only,
    output logic               rec_valid,
    output trace_pkg::rec_t    rec_data
);

    import trace_pkg::*;

    logic [31:0] cycle_cnt;
    logic        keep;

    // stage 1, raw retire facts
    logic        s1_valid;
    logic [31:0] s1_stamp;
    logic [31:0] s1_pc;
    insn_u       s1_insn;
    logic        s1_trap;
    logic        s1_rd_we;
    logic [4:0]  s1_rd_addr;
    logic [31:0] s1_rd_wdata;
    logic        s1_csr_we;
    logic [31:0] s1_csr_wdata;

    // decode of stage 1
    insn_class_e cls;
    logic [11:0] csr_addr;
    logic        rd_flag;
    logic [31:0] data_word;
    logic [31:0] meta_word;

    // free-running, reads 0 at first edge after reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    // filter with live cfg
    assign keep = ret_valid && cfg_enable && (!cfg_trap_only || ret_trap);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= keep;
        end
    end

    // payload, no reset
    always_ff @(posedge clk_i) begin
        if (keep) begin
            s1_stamp     <= cycle_cnt;
            s1_pc        <= ret_pc;
            s1_insn      <= ret_insn;
            s1_trap      <= ret_trap;
            s1_rd_we     <= ret_rd_we;
            s1_rd_addr   <= ret_rd_addr;
            s1_rd_wdata  <= ret_rd_wdata;
            s1_csr_we    <= ret_csr_we;
            s1_csr_wdata <= ret_csr_wdata;
        end
    end

    // opcode class from base view
    always_comb begin
        case (s1_insn.base.opcode)
            opc_load_lp:   cls = class_load;
            opc_store_lp:  cls = class_store;
            opc_branch_lp: cls = class_branch;
            opc_jal_lp:    cls = class_jal;
            opc_jalr_lp:   cls = class_jalr;
            opc_op_lp:     cls = class_op;
            opc_op_imm_lp: cls = class_op_imm;
            opc_lui_lp:    cls = class_lui;
            opc_auipc_lp:  cls = class_auipc;
            opc_system_lp: cls = class_system;
            default:       cls = class_other;
        endcase
    end

    // csr number only meaningful for system
    assign csr_addr = (cls == class_system) ? s1_insn.sys.csr : 12'd0;

    // x0 writes show as no write
    assign rd_flag = s1_rd_we && (s1_rd_addr != 5'd0);

    always_comb begin
        if (s1_csr_we) begin
            data_word = s1_csr_wdata;
        end else if (s1_rd_we && (s1_rd_addr == 5'd0)) begin
            data_word = 32'd0;
        end else begin
            data_word = s1_rd_wdata;
        end
    end

    always_comb begin
        meta_word = '0;
        meta_word[meta_trap_bit_lp] = s1_trap;
        meta_word[meta_rd_we_bit_lp] = rd_flag;
        meta_word[meta_csr_we_bit_lp] = s1_csr_we;
        meta_word[meta_rd_lsb_lp +: 5] = s1_rd_addr;
        meta_word[meta_csr_lsb_lp +: 12] = csr_addr;
        meta_word[meta_class_lsb_lp +: 4] = cls;
    end

    // stage 2, assembled record toward the fifo
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid) begin
            rec_data[rec_stamp_lp] <= s1_stamp;
            rec_data[rec_pc_lp]    <= s1_pc;
            rec_data[rec_insn_lp]  <= s1_insn;
            rec_data[rec_data_lp]  <= data_word;
            rec_data[rec_meta_lp]  <= meta_word;
        end
    end

endmodule

//--- trace_fifo.sv
`timescale 1ns/1ps

module trace_fifo (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               push,
    input  trace_pkg::rec_t                    push_data,
    input  logic                               pop,
    input  logic                               ovf_clear,
    output trace_pkg::rec_t                    head,
    output logic [trace_pkg::level_w_lp-1:0]   level,
    output logic [trace_pkg::ovf_w_lp-1:0]     ovf_count
);

    import trace_pkg::*;

    rec_t                mem [fifo_depth_lp];
    logic [ptr_w_lp-1:0] wr_ptr;
    logic [ptr_w_lp-1:0] rd_ptr;
    logic                do_pop;
    logic                do_push;
    logic                full;

    assign full = (level == level_w_lp'(fifo_depth_lp));
    // empty pops are ignored
    assign do_pop = pop && (level != '0);
    // full fifo still takes a push when a pop frees a slot
    assign do_push = push && (!full || do_pop);

    assign head = mem[rd_ptr];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w_lp'(fifo_depth_lp - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w_lp'(fifo_depth_lp - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // net level change
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    // storage, no reset
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // lost records, saturating, clear wins
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ovf_count <= '0;
        end else if (ovf_clear) begin
            ovf_count <= '0;
        end else if (push && !do_push && (ovf_count != '1)) begin
            ovf_count <= ovf_count + 1'b1;
        end
    end

endmodule

//--- trace_regs.sv
`timescale 1ns/1ps

module trace_regs (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    // write address
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [trace_pkg::axi_addr_w_lp-1:0]   awaddr,
    // write data
    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [31:0]                           wdata,
    input  logic [3:0]                            wstrb,
    // write response
    output logic                                  bvalid,
    input  logic                                  bready,
    output logic [1:0]                            bresp,
    // read address
    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [trace_pkg::axi_addr_w_lp-1:0]   araddr,
    // read data
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [31:0]                           rdata,
    output logic [1:0]                            rresp,
    // fifo side
    input  trace_pkg::rec_t                       head,
    input  logic [trace_pkg::level_w_lp-1:0]      level,
    input  logic [trace_pkg::ovf_w_lp-1:0]        ovf_count,
    output logic                                  cfg_enable,
    output logic                                  cfg_trap_only,
    output logic                                  pop,
    output logic                                  ovf_clear
);

    import trace_pkg::*;

    logic        wr_accept;
    logic        rd_accept;
    logic        empty;
    logic [31:0] status_word;
    logic [31:0] rd_word;

    // address and data taken together while no response is pending
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready = wr_accept;
    assign wready = wr_accept;

    assign rd_accept = arvalid && !rvalid;
    assign arready = rd_accept;

    // always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // ctrl reads back as written
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_enable    <= 1'b0;
            cfg_trap_only <= 1'b0;
        end else if (wr_accept && (awaddr == reg_ctrl_lp)) begin
            cfg_enable    <= wdata[0];
            cfg_trap_only <= wdata[1];
        end
    end

    // any status write clears the lost count
    assign ovf_clear = wr_accept && (awaddr == reg_status_lp);

    assign empty = (level == '0);

    always_comb begin
        status_word = '0;
        status_word[level_w_lp-1:0] = level;
        status_word[8] = empty;
        status_word[31:16] = ovf_count;
    end

    // unmapped reads give zero
    always_comb begin
        case (araddr)
            reg_ctrl_lp:   rd_word = {30'd0, cfg_trap_only, cfg_enable};
            reg_status_lp: rd_word = status_word;
            reg_rec0_lp:   rd_word = head[rec_stamp_lp];
            reg_rec1_lp:   rd_word = head[rec_pc_lp];
            reg_rec2_lp:   rd_word = head[rec_insn_lp];
            reg_rec3_lp:   rd_word = head[rec_data_lp];
            reg_rec4_lp:   rd_word = head[rec_meta_lp];
            default:       rd_word = 32'd0;
        endcase
    end

    // head advances on the same edge rdata is taken
    assign pop = rd_accept && (araddr == reg_rec4_lp) && !empty;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // held while rvalid waits on rready
    always_ff @(posedge clk_i) begin
        if (rd_accept) begin
            rdata <= rd_word;
        end
    end

endmodule

//--- trace_top.sv
`timescale 1ns/1ps

module trace_top (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    // retire port, no handshake
    input  logic                                  ret_valid,
    input  logic [31:0]                           ret_pc,
    input  logic [31:0]                           ret_insn,
    input  logic                                  ret_trap,
    input  logic                                  ret_rd_we,
    input  logic [4:0]                            ret_rd_addr,
    input  logic [31:0]                           ret_rd_wdata,
    input  logic                                  ret_csr_we,
    input  logic [31:0]                           ret_csr_wdata,
    // axi4-lite slave
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [trace_pkg::axi_addr_w_lp-1:0]   awaddr,
    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [31:0]                           wdata,
    input  logic [3:0]                            wstrb,
    output logic                                  bvalid,
    input  logic                                  bready,
    output logic [1:0]                            bresp,
    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [trace_pkg::axi_addr_w_lp-1:0]   araddr,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [31:0]                           rdata,
    output logic [1:0]                            rresp
);

    import trace_pkg::*;

    logic                  cfg_enable;
    logic                  cfg_trap_only;
    logic                  rec_valid;
    rec_t                  rec_data;
    logic                  pop;
    logic                  ovf_clear;
    rec_t                  head;
    logic [level_w_lp-1:0] level;
    logic [ovf_w_lp-1:0]   ovf_count;

    // retire sampling and record build
    trace_capture u_capture (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ret_valid     (ret_valid),
        .ret_pc        (ret_pc),
        .ret_insn      (ret_insn),
        .ret_trap      (ret_trap),
        .ret_rd_we     (ret_rd_we),
        .ret_rd_addr   (ret_rd_addr),
        .ret_rd_wdata  (ret_rd_wdata),
        .ret_csr_we    (ret_csr_we),
        .ret_csr_wdata (ret_csr_wdata),
        .cfg_enable    (cfg_enable),
        .cfg_trap_only (cfg_trap_only),
        .rec_valid     (rec_valid),
        .rec_data      (rec_data)
    );

    trace_fifo u_fifo (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .push      (rec_valid),
        .push_data (rec_data),
        .pop       (pop),
        .ovf_clear (ovf_clear),
        .head      (head),
        .level     (level),
        .ovf_count (ovf_count)
    );

    // software view
    trace_regs u_regs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .rresp         (rresp),
        .head          (head),
        .level         (level),
        .ovf_count     (ovf_count),
        .cfg_enable    (cfg_enable),
        .cfg_trap_only (cfg_trap_only),
        .pop           (pop),
        .ovf_clear     (ovf_clear)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    localparam int half_period_lp = 4;

    initial begin
        clk = 1'b0;
        forever #half_period_lp clk = ~clk;
    end

    // hold through five rising edges, release on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- trace_tb.sv
`timescale 1ns/1ps

module trace_tb;

    import trace_pkg::*;

    localparam int clk_period_lp = 8;
    localparam int cycles_per_line_lp = 200;

    logic        clk;
    logic        rst_n;
    logic        ret_valid;
    logic [31:0] ret_pc;
    logic [31:0] ret_insn;
    logic        ret_trap;
    logic        ret_rd_we;
    logic [4:0]  ret_rd_addr;
    logic [31:0] ret_rd_wdata;
    logic        ret_csr_we;
    logic [31:0] ret_csr_wdata;
    logic        awvalid;
    logic        awready;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [7:0]  araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    // tb side model
    logic [31:0]  tb_cycle;
    logic [159:0] exp_q[$];
    int           stall_max;
    int           case_lines;
    logic         limit_ready;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    trace_top u_trace_top (
        .clk_i (clk), .rst_n_i (rst_n),
        .ret_valid (ret_valid), .ret_pc (ret_pc), .ret_insn (ret_insn),
        .ret_trap (ret_trap), .ret_rd_we (ret_rd_we), .ret_rd_addr (ret_rd_addr),
        .ret_rd_wdata (ret_rd_wdata), .ret_csr_we (ret_csr_we),
        .ret_csr_wdata (ret_csr_wdata),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    // cycle count from reset release, mirrors the stamp rule
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tb_cycle <= '0;
        end else begin
            tb_cycle <= tb_cycle + 32'd1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_bad_line(input logic [8*16-1:0] cmd);
        $display("case file line starting with '%0s' is malformed or unknown", cmd);
        $display("TEST FAILED");
        $fatal(1, "bad case line");
    endtask

    function automatic string word_name(input int k);
        case (k)
            0: return "rec0 stamp";
            1: return "rec1 pc";
            2: return "rec2 insn";
            3: return "rec3 data";
            default: return "rec4 meta";
        endcase
    endfunction

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        // ready is combinational, look at it mid-cycle
        @(negedge clk);
        while (!(awready && wready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        check_value("bresp", 32'(bresp), 32'h0);
        // bready stays high, response taken here
        @(posedge clk);
    endtask

    task automatic axi_read(input logic [7:0] addr, input int stall,
                            output logic [31:0] data);
        logic [31:0] held;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= 1'b0;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        held = rdata;
        check_value("rresp", 32'(rresp), 32'h0);
        // rready low, data has to sit still
        repeat (stall) begin
            @(negedge clk);
            check_value("rvalid", 32'(rvalid), 32'h1);
            check_value("rdata", rdata, held);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        data = held;
    endtask

    task automatic write_ctrl(input logic [31:0] value);
        logic [31:0] got;
        axi_write(reg_ctrl_lp, value);
        axi_read(reg_ctrl_lp, 0, got);
        check_value("ctrl", got, value & 32'h3);
    endtask

    task automatic check_status(input logic [31:0] lvl, input logic [31:0] empty_bit,
                                input logic [31:0] ovf);
        logic [31:0] got;
        logic [31:0] exp_word;
        // let the last retirement land in the fifo
        repeat (4) @(posedge clk);
        exp_word = {ovf[15:0], 7'd0, empty_bit[0], 4'd0, lvl[3:0]};
        axi_read(reg_status_lp, 0, got);
        check_value("status", got, exp_word);
    endtask

    task automatic drive_retire(input logic [31:0] pc, input logic [31:0] insn,
                                input logic [31:0] trap, input logic [31:0] rd_we,
                                input logic [31:0] rd_addr, input logic [31:0] rd_wdata,
                                input logic [31:0] csr_we, input logic [31:0] csr_wdata,
                                input logic [31:0] keep, input logic [31:0] cls);
        logic [31:0] stamp;
        logic [31:0] data_word;
        logic [31:0] meta_word;
        logic [11:0] csr_addr;
        logic        rd_flag;
        int          gap;
        @(posedge clk);
        ret_valid     <= 1'b1;
        ret_pc        <= pc;
        ret_insn      <= insn;
        ret_trap      <= trap[0];
        ret_rd_we     <= rd_we[0];
        ret_rd_addr   <= rd_addr[4:0];
        ret_rd_wdata  <= rd_wdata;
        ret_csr_we    <= csr_we[0];
        ret_csr_wdata <= csr_wdata;
        // count after this edge is what the next edge stamps
        @(negedge clk);
        stamp = tb_cycle;
        @(posedge clk);
        ret_valid <= 1'b0;
        // x0 target counts as no write, data zeroed
        rd_flag = rd_we[0] && (rd_addr[4:0] != 5'd0);
        if (csr_we[0]) begin
            data_word = csr_wdata;
        end else if (rd_we[0] && (rd_addr[4:0] == 5'd0)) begin
            data_word = 32'd0;
        end else begin
            data_word = rd_wdata;
        end
        csr_addr = (cls[3:0] == 4'd9) ? insn[31:20] : 12'd0;
        meta_word = {8'h00, cls[3:0], csr_addr, rd_addr[4:0], csr_we[0], rd_flag, trap[0]};
        // full fifo drops the record
        if (keep[0] && (exp_q.size() < fifo_depth_lp)) begin
            exp_q.push_back({meta_word, data_word, insn, pc, stamp});
        end
        gap = int'($urandom % 4);
        repeat (gap) @(posedge clk);
    endtask

    task automatic drain_records(input int count);
        logic [159:0] exp_rec;
        logic [31:0]  got;
        int           stall;
        int           i;
        int           k;
        repeat (4) @(posedge clk);
        for (i = 0; i < count; i++) begin
            if (exp_q.size() == 0) begin
                $display("drain asked for more records than the model holds");
                $display("TEST FAILED");
                $fatal(1, "expected queue empty");
            end else begin
                exp_rec = exp_q.pop_front();
                // rec4 last, its read pops the head
                for (k = 0; k < rec_words_lp; k++) begin
                    stall = (stall_max > 0) ? int'($urandom % (stall_max + 1)) : 0;
                    axi_read(reg_rec0_lp + 8'(4 * k), stall, got);
                    check_value(word_name(k), got, exp_rec[32*k +: 32]);
                end
            end
        end
    endtask

    initial begin : watchdog
        wait (limit_ready);
        #(case_lines * cycles_per_line_lp * clk_period_lp + 10 * clk_period_lp);
        $display("run timed out before the case file was finished");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int              fd;
        int              rc;
        int              n;
        logic [8*16-1:0] word;
        logic [8*128-1:0] line;
        logic [31:0]     f_pc;
        logic [31:0]     f_insn;
        logic [31:0]     f_trap;
        logic [31:0]     f_rd_we;
        logic [31:0]     f_rd_addr;
        logic [31:0]     f_rd_wdata;
        logic [31:0]     f_csr_we;
        logic [31:0]     f_csr_wdata;
        logic [31:0]     f_keep;
        logic [31:0]     f_cls;
        logic [31:0]     f_a;
        logic [31:0]     f_b;
        logic [31:0]     f_c;
        void'($urandom(32'hbefe_d53e));
        limit_ready = 1'b0;
        case_lines = 0;
        stall_max = 0;
        ret_valid <= 1'b0;
        ret_pc <= '0;
        ret_insn <= '0;
        ret_trap <= 1'b0;
        ret_rd_we <= 1'b0;
        ret_rd_addr <= '0;
        ret_rd_wdata <= '0;
        ret_csr_we <= 1'b0;
        ret_csr_wdata <= '0;
        awvalid <= 1'b0;
        awaddr <= '0;
        wvalid <= 1'b0;
        wdata <= '0;
        wstrb <= 4'hf;
        bready <= 1'b1;
        arvalid <= 1'b0;
        araddr <= '0;
        rready <= 1'b0;
        // first pass sizes the watchdog
        fd = $fopen("trace_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open trace_cases.txt");
            $display("TEST FAILED");
            $fatal(1, "no case file");
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0) begin
                case_lines++;
            end
        end
        $fclose(fd);
        limit_ready = 1'b1;
        wait (rst_n == 1'b1);
        @(posedge clk);
        fd = $fopen("trace_cases.txt", "r");
        while (!$feof(fd)) begin
            word = '0;
            n = $fscanf(fd, "%s", word);
            if (n == 1) begin
                if (word == 128'("#")) begin
                    rc = $fgets(line, fd);
                end else if (word == 128'("ret")) begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f_pc, f_insn, f_trap,
                                f_rd_we, f_rd_addr, f_rd_wdata, f_csr_we, f_csr_wdata,
                                f_keep, f_cls);
                    if (n != 10) begin
                        report_bad_line(word);
                    end
                    drive_retire(f_pc, f_insn, f_trap, f_rd_we, f_rd_addr, f_rd_wdata,
                                 f_csr_we, f_csr_wdata, f_keep, f_cls);
                end else if (word == 128'("ctrl")) begin
                    n = $fscanf(fd, "%h", f_a);
                    if (n != 1) begin
                        report_bad_line(word);
                    end
                    write_ctrl(f_a);
                end else if (word == 128'("status")) begin
                    n = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                    if (n != 3) begin
                        report_bad_line(word);
                    end
                    check_status(f_a, f_b, f_c);
                end else if (word == 128'("drain")) begin
                    n = $fscanf(fd, "%h", f_a);
                    if (n != 1) begin
                        report_bad_line(word);
                    end
                    drain_records(int'(f_a));
                end else if (word == 128'("stall")) begin
                    n = $fscanf(fd, "%h", f_a);
                    if (n != 1) begin
                        report_bad_line(word);
                    end
                    stall_max = int'(f_a);
                end else if (word == 128'("clrovf")) begin
                    axi_write(reg_status_lp, 32'h0);
                end else begin
                    report_bad_line(word);
                end
            end
        end
        $fclose(fd);
        // every kept record must have been drained
        check_value("undrained records", 32'(exp_q.size()), 32'h0);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- trace_cases.txt
# ret pc insn trap rd_we rd_addr rd_wdata csr_we csr_wdata keep class (all hex)
# ctrl value | status level empty ovf | drain count | stall max_cycles | clrovf
ctrl 1
ret 80000000 00812283 0 1 05 00001234 0 00000000 1 0
ret 80000004 00112623 0 0 00 00000000 0 00000000 1 1
ret 80000008 00208463 0 0 00 00000000 0 00000000 1 2
ret 80000010 008000ef 0 1 01 80000014 0 00000000 1 3
ret 80000018 00008067 0 1 00 00001044 0 00000000 1 4
ret 80000014 002081b3 0 1 03 00000007 0 00000000 1 5
status 6 0 0
drain 6
ret 8000001c 00000013 0 1 00 deadbeef 0 00000000 1 6
ret 80000020 123453b7 0 1 07 12345000 0 00000000 1 7
ret 80000024 00000417 0 1 08 80000024 0 00000000 1 8
ret 80000028 30531073 0 0 00 00000000 1 80000100 1 9
ret 8000002c 300024f3 0 1 09 00001800 0 00000000 1 9
ret 80000030 0ff0000f 0 0 00 00000000 0 00000000 1 a
drain 6
# disabled, then trap-only
ctrl 0
ret 80000034 00100093 0 1 01 00000001 0 00000000 0 6
status 0 1 0
ctrl 3
ret 80000038 00200113 0 1 02 00000002 0 00000000 0 6
ret 8000003c 00000073 1 0 00 00000000 0 00000000 1 9
ret 80000100 00300193 0 1 03 00000003 0 00000000 0 6
ret 80000104 00000000 1 0 00 00000000 0 00000000 1 a
status 2 0 0
drain 2
# ten records into eight slots, stalled drain
ctrl 1
ret 80000200 00100093 0 1 01 00000001 0 00000000 1 6
ret 80000204 00200113 0 1 02 00000002 0 00000000 1 6
ret 80000208 00300193 0 1 03 00000003 0 00000000 1 6
ret 8000020c 00400213 0 1 04 00000004 0 00000000 1 6
ret 80000210 00500293 0 1 05 00000005 0 00000000 1 6
ret 80000214 00600313 0 1 06 00000006 0 00000000 1 6
ret 80000218 00700393 0 1 07 00000007 0 00000000 1 6
ret 8000021c 00800413 0 1 08 00000008 0 00000000 1 6
ret 80000220 00900493 0 1 09 00000009 0 00000000 1 6
ret 80000224 00a00513 0 1 0a 0000000a 0 00000000 1 6
status 8 0 2
stall 6
drain 8
status 0 1 2
clrovf
status 0 1 0

//--- trace_top.f
trace_pkg.sv
trace_capture.sv
trace_fifo.sv
trace_regs.sv
trace_top.sv
tb_clock_gen.sv
trace_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the trace unit testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module trace_tb -f trace_top.f -o trace_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/trace_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
